// ==== Bender.yml ====
package:
  name: io_hub

sources:
  - files:
      - hw/io_hub_pkg.sv
      - hw/host_cmd_decoder.sv
      - hw/audio_channel_mix.sv
      - hw/panel_io.sv
      - hw/io_hub_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_io_hub.sv

// ==== all.f ====
+incdir+tb
hw/io_hub_pkg.sv
hw/host_cmd_decoder.sv
hw/audio_channel_mix.sv
hw/panel_io.sv
hw/io_hub_top.sv
tb/tb_io_hub.sv

// ==== hw/audio_channel_mix.sv ====
// Audio channel mixer

`timescale 1ns/10ps
`default_nettype none

module audio_channel_mix (
	input  wire                        clk,
	input  wire                        resetd,
	input  wire io_hub_pkg::audio_ctl_t i_ctl,
	input  wire io_hub_pkg::sample_t   i_core,
	input  wire io_hub_pkg::sample_t   i_linux,
	input  wire io_hub_pkg::sample_t   i_pre,
	output io_hub_pkg::sample_t        o_pre,
	output io_hub_pkg::sample_t        o_out
);

	// Core sample delay line and the accepted value
	logic [15:0] core_d1;
	logic [15:0] core_d2;
	logic [15:0] core_stable;

	logic signed [16:0] a1;
	logic signed [16:0] a2;
	logic signed [16:0] a3;
	logic signed [16:0] a4;
	logic signed [16:0] linux_ext;
	logic signed [16:0] pre_ext;
	io_hub_pkg::sample_t out_q;

	////////////////////////////////////////////////////////////
	// Stabilizer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			core_d1     <= '0;
			core_d2     <= '0;
			core_stable <= '0;
		end else begin
			core_d1 <= i_core;
			core_d2 <= core_d1;
			// Take it only when two stages agree
			if (core_d1 == core_d2)
				core_stable <= core_d2;
		end
	end

	assign linux_ext = i_linux;
	assign pre_ext   = i_pre;

	////////////////////////////////////////////////////////////
	// Arithmetic pipeline
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			a1    <= '0;
			a2    <= '0;
			a3    <= '0;
			out_q <= '0;
		end else begin
			// Unsigned core is halved into the positive range
			if (i_ctl.is_signed)
				a1 <= {core_stable[15], core_stable};
			else
				a1 <= {2'b00, core_stable[15:1]};

			a2 <= a1 + linux_ext;

			case (i_ctl.mix)
				io_hub_pkg::MIX_EIGHTH:  a3 <= a2 - (a2 >>> 3) + (pre_ext >>> 2);
				io_hub_pkg::MIX_QUARTER: a3 <= a2 - (a2 >>> 2) + (pre_ext >>> 1);
				io_hub_pkg::MIX_MONO:    a3 <= (a2 >>> 1) + pre_ext;
				default:                 a3 <= a2;
			endcase

			// Clamp to 16 bits on overflow
			if (a4[16] ^ a4[15])
				out_q <= {a4[16], {15{~a4[16]}}};
			else
				out_q <= a4[15:0];
		end
	end

	// Volume stage
	assign a4 = i_ctl.att.mute ? 17'sd0 : (a3 >>> i_ctl.att.shift);

	assign o_pre = a2[16:1];
	assign o_out = out_q;

endmodule

`default_nettype wire

// ==== hw/host_cmd_decoder.sv ====
// Host command decoder

`timescale 1ns/10ps
`default_nettype none

module host_cmd_decoder (
	input  wire                        clk,
	input  wire                        resetd,
	input  wire                        i_io_sel,
	input  wire                        i_io_strobe,
	input  wire io_hub_pkg::host_word_t i_io_din,
	output io_hub_pkg::led_cfg_t       o_led_cfg,
	output io_hub_pkg::vol_att_t       o_att
);

	logic                   sel_q;
	logic                   strobe_q;
	logic                   strobe_qq;
	io_hub_pkg::host_word_t din_q;
	logic                   word_rise;

	logic                   has_cmd;
	io_hub_pkg::cmd_e       cmd;
	io_hub_pkg::led_cfg_t   led_cfg_q;
	io_hub_pkg::vol_att_t   att_q;

	////////////////////////////////////////////////////////////
	// Input stage and strobe edge
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			sel_q     <= 1'b0;
			strobe_q  <= 1'b0;
			strobe_qq <= 1'b0;
		end else begin
			sel_q     <= i_io_sel;
			strobe_q  <= i_io_strobe;
			strobe_qq <= strobe_q;
		end
	end

	// Data word is captured alongside the strobe
	always_ff @(posedge clk) begin
		din_q <= i_io_din;
	end

	assign word_rise = strobe_q & ~strobe_qq;

	////////////////////////////////////////////////////////////
	// Command and data sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd   <= 1'b0;
			cmd       <= io_hub_pkg::CMD_NONE;
			led_cfg_q <= '0;
			att_q     <= '0;
		end else if (!sel_q) begin
			// Deselect drops any pending command
			has_cmd <= 1'b0;
			cmd     <= io_hub_pkg::CMD_NONE;
		end else if (word_rise) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= io_hub_pkg::cmd_e'(din_q[io_hub_pkg::CMD_W-1:0]);
			end else begin
				// Every data word rewrites, last one wins
				case (cmd)
					io_hub_pkg::CMD_LED: begin
						led_cfg_q <= io_hub_pkg::led_cfg_t'(din_q);
					end
					io_hub_pkg::CMD_VOLUME: begin
						att_q <= io_hub_pkg::vol_att_t'(din_q[4:0]);
					end
					default: begin
						// Unknown opcode, data ignored
					end
				endcase
			end
		end
	end

	assign o_led_cfg = led_cfg_q;
	assign o_att     = att_q;

endmodule

`default_nettype wire

// ==== hw/io_hub_pkg.sv ====
// Host I/O hub shared types

`default_nettype none

package io_hub_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	localparam int HOST_W    = 16;
	localparam int CMD_W     = 8;
	localparam int SAMPLE_W  = 16;
	localparam int LED_COUNT = 8;

	// One word on the host port
	typedef logic [HOST_W-1:0] host_word_t;

	// Host opcodes, taken from the low byte of the first word
	typedef enum logic [CMD_W-1:0] {
		CMD_NONE   = 8'h00,
		CMD_LED    = 8'h25,
		CMD_VOLUME = 8'h26
	} cmd_e;

	// LED override, overtake in the high byte
	typedef struct packed {
		logic [LED_COUNT-1:0] overtake;
		logic [LED_COUNT-1:0] state;
	} led_cfg_t;

	// System status, 1 means active
	typedef struct packed {
		logic locked;
		logic power;
		logic disk;
		logic user;
	} status_leds_t;

	////////////////////////////////////////////////////////////
	// Audio
	////////////////////////////////////////////////////////////

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Attenuation word as written by the host
	typedef struct packed {
		logic       mute;
		logic [3:0] shift;
	} vol_att_t;

	// Cross-mix amount between left and right
	typedef enum logic [1:0] {
		MIX_NONE    = 2'd0,
		MIX_EIGHTH  = 2'd1,
		MIX_QUARTER = 2'd2,
		MIX_MONO    = 2'd3
	} mix_mode_e;

	// Shared by both mixer channels
	typedef struct packed {
		mix_mode_e mix;
		logic      is_signed;
		vol_att_t  att;
	} audio_ctl_t;

endpackage

`default_nettype wire

// ==== hw/io_hub_top.sv ====
// Host I/O hub top level

`timescale 1ns/10ps
`default_nettype none

module io_hub_top #(
	parameter int DEBOUNCE_DIV = 100000
) (
	input  wire                          clk,
	input  wire                          resetd,
	input  wire                          i_io_sel,
	input  wire                          i_io_strobe,
	input  wire io_hub_pkg::host_word_t  i_io_din,
	input  wire                          i_btn_user,
	input  wire                          i_btn_osd,
	input  wire io_hub_pkg::status_leds_t i_status,
	input  wire io_hub_pkg::mix_mode_e   i_mix_mode,
	input  wire                          i_core_signed,
	input  wire io_hub_pkg::sample_t     i_core_l,
	input  wire io_hub_pkg::sample_t     i_core_r,
	input  wire io_hub_pkg::sample_t     i_linux_l,
	input  wire io_hub_pkg::sample_t     i_linux_r,
	output logic                         o_btn_user,
	output logic                         o_btn_osd,
	output logic [io_hub_pkg::LED_COUNT-1:0] o_led,
	output io_hub_pkg::sample_t          o_audio_l,
	output io_hub_pkg::sample_t          o_audio_r
);

	io_hub_pkg::led_cfg_t   led_cfg;
	io_hub_pkg::vol_att_t   vol_att;
	io_hub_pkg::audio_ctl_t audio_ctl;
	io_hub_pkg::sample_t    pre_l;
	io_hub_pkg::sample_t    pre_r;

	host_cmd_decoder cmd_dec (
		.clk        (clk),
		.resetd     (resetd),
		.i_io_sel   (i_io_sel),
		.i_io_strobe(i_io_strobe),
		.i_io_din   (i_io_din),
		.o_led_cfg  (led_cfg),
		.o_att      (vol_att)
	);

	panel_io #(
		.DEBOUNCE_DIV(DEBOUNCE_DIV)
	) panel (
		.clk       (clk),
		.resetd    (resetd),
		.i_btn_user(i_btn_user),
		.i_btn_osd (i_btn_osd),
		.i_led_cfg (led_cfg),
		.i_status  (i_status),
		.o_btn_user(o_btn_user),
		.o_btn_osd (o_btn_osd),
		.o_led     (o_led)
	);

	// Same control word for both channels
	assign audio_ctl = '{mix: i_mix_mode, is_signed: i_core_signed, att: vol_att};

	// Each channel's half sum feeds the other side
	audio_channel_mix mix_l (
		.clk    (clk),
		.resetd (resetd),
		.i_ctl  (audio_ctl),
		.i_core (i_core_l),
		.i_linux(i_linux_l),
		.i_pre  (pre_r),
		.o_pre  (pre_l),
		.o_out  (o_audio_l)
	);

	audio_channel_mix mix_r (
		.clk    (clk),
		.resetd (resetd),
		.i_ctl  (audio_ctl),
		.i_core (i_core_r),
		.i_linux(i_linux_r),
		.i_pre  (pre_l),
		.o_pre  (pre_r),
		.o_out  (o_audio_r)
	);

endmodule

`default_nettype wire

// ==== hw/panel_io.sv ====
// Front panel buttons and LEDs

`timescale 1ns/10ps
`default_nettype none

module panel_io #(
	parameter int DEBOUNCE_DIV = 100000
) (
	input  wire                          clk,
	input  wire                          resetd,
	input  wire                          i_btn_user,
	input  wire                          i_btn_osd,
	input  wire io_hub_pkg::led_cfg_t    i_led_cfg,
	input  wire io_hub_pkg::status_leds_t i_status,
	output logic                         o_btn_user,
	output logic                         o_btn_osd,
	output logic [io_hub_pkg::LED_COUNT-1:0] o_led
);

	localparam int DIV_W  = (DEBOUNCE_DIV > 0) ? $clog2(DEBOUNCE_DIV + 1) : 1;
	localparam int HIST_W = 8;

	logic [DIV_W-1:0]  div_cnt;
	logic              tick;
	logic [1:0]        btn_raw;
	logic [HIST_W-1:0] hist [2];
	logic [1:0]        btn_q;
	logic [io_hub_pkg::LED_COUNT-1:0] status_pattern;

	////////////////////////////////////////////////////////////
	// Debounce tick
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd)
			div_cnt <= '0;
		else if (div_cnt == DIV_W'(DEBOUNCE_DIV))
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	assign tick = (div_cnt == '0);

	// Index 0 is user, 1 is OSD
	assign btn_raw = {i_btn_osd, i_btn_user};

	always_ff @(posedge clk) begin
		if (resetd) begin
			for (int i = 0; i < 2; i++)
				hist[i] <= '0;
			btn_q <= '0;
		end else if (tick) begin
			for (int i = 0; i < 2; i++) begin
				hist[i] <= {hist[i][HIST_W-2:0], btn_raw[i]};
				// Change only on a full run of equal samples
				if (&hist[i])
					btn_q[i] <= 1'b1;
				if (hist[i] == '0)
					btn_q[i] <= 1'b0;
			end
		end
	end

	assign o_btn_user = btn_q[0];
	assign o_btn_osd  = btn_q[1];

	////////////////////////////////////////////////////////////
	// LED merge
	////////////////////////////////////////////////////////////

	assign status_pattern = {1'b0, i_status.locked, 1'b0, i_status.power,
	                         1'b0, i_status.disk, 1'b0, i_status.user};

	// Host overtake bits pick the state bit per LED
	assign o_led = (i_led_cfg.overtake & i_led_cfg.state) |
	               (~i_led_cfg.overtake & status_pattern);

endmodule

`default_nettype wire

// ==== tb/tb_io_hub_tasks.svh ====
// Host I/O hub testbench tasks

`ifndef TB_IO_HUB_TASKS_SVH
`define TB_IO_HUB_TASKS_SVH

////////////////////////////////////////////////////////////
// Drive
////////////////////////////////////////////////////////////

task automatic wait_cycles(input int n);
	repeat (n) @(negedge clk);
endtask

task automatic host_select(input logic level);
	@(negedge clk);
	i_io_sel = level;
	wait_cycles(2);
endtask

// Strobe high for two cycles, then low for two
task automatic send_word(input io_hub_pkg::host_word_t word);
	@(negedge clk);
	i_io_din    = word;
	i_io_strobe = 1'b1;
	wait_cycles(2);
	i_io_strobe = 1'b0;
	wait_cycles(2);
endtask

task automatic host_write(input logic [7:0] opcode, input int count,
		input io_hub_pkg::host_word_t first, input io_hub_pkg::host_word_t second);
	host_select(1'b1);
	send_word({8'h00, opcode});
	if (count > 0)
		send_word(first);
	if (count > 1)
		send_word(second);
	host_select(1'b0);
endtask

task automatic set_button(input logic osd, input logic level);
	@(negedge clk);
	if (osd)
		i_btn_osd = level;
	else
		i_btn_user = level;
endtask

// Longer than the 10 cycle settle bound
task automatic drive_audio(input io_hub_pkg::sample_t core_l, input io_hub_pkg::sample_t linux_l,
		input io_hub_pkg::sample_t core_r, input io_hub_pkg::sample_t linux_r);
	@(negedge clk);
	i_core_l  = core_l;
	i_linux_l = linux_l;
	i_core_r  = core_r;
	i_linux_r = linux_r;
	wait_cycles(16);
endtask

////////////////////////////////////////////////////////////
// Reference models
////////////////////////////////////////////////////////////

function automatic logic [io_hub_pkg::LED_COUNT-1:0] led_expect(
		input io_hub_pkg::led_cfg_t cfg, input io_hub_pkg::status_leds_t st);
	logic [io_hub_pkg::LED_COUNT-1:0] leds;
	leds = {1'b0, st.locked, 1'b0, st.power, 1'b0, st.disk, 1'b0, st.user};
	for (int i = 0; i < io_hub_pkg::LED_COUNT; i++) begin
		if (cfg.overtake[i])
			leds[i] = cfg.state[i];
	end
	return leds;
endfunction

// Core plus Linux sample, before the cross-mix
function automatic int model_sum(input io_hub_pkg::sample_t core,
		input io_hub_pkg::sample_t linux_smp, input logic is_signed);
	logic [15:0] raw;
	int          a1;
	raw = core;
	if (is_signed)
		a1 = core;
	else
		a1 = raw >> 1;
	return a1 + linux_smp;
endfunction

function automatic io_hub_pkg::sample_t model_out(input int own, input int other,
		input io_hub_pkg::mix_mode_e mix, input io_hub_pkg::vol_att_t att);
	int pre;
	int v;
	pre = other >>> 1;
	case (mix)
		io_hub_pkg::MIX_EIGHTH:  v = own - (own >>> 3) + (pre >>> 2);
		io_hub_pkg::MIX_QUARTER: v = own - (own >>> 2) + (pre >>> 1);
		io_hub_pkg::MIX_MONO:    v = (own >>> 1) + pre;
		default:                 v = own;
	endcase
	v = att.mute ? 0 : (v >>> att.shift);
	if (v > 32767)
		v = 32767;
	else if (v < -32768)
		v = -32768;
	return io_hub_pkg::sample_t'(v);
endfunction

////////////////////////////////////////////////////////////
// Compare
////////////////////////////////////////////////////////////

task automatic compare_sample(input string name, input io_hub_pkg::sample_t got,
		input io_hub_pkg::sample_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
	end
endtask

task automatic compare_led(input string name, input logic [io_hub_pkg::LED_COUNT-1:0] got,
		input logic [io_hub_pkg::LED_COUNT-1:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
	end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
	end
endtask

task automatic check_audio();
	int sum_l;
	int sum_r;
	sum_l = model_sum(i_core_l, i_linux_l, i_core_signed);
	sum_r = model_sum(i_core_r, i_linux_r, i_core_signed);
	compare_sample("o_audio_l", o_audio_l, model_out(sum_l, sum_r, i_mix_mode, exp_att));
	compare_sample("o_audio_r", o_audio_r, model_out(sum_r, sum_l, i_mix_mode, exp_att));
endtask

task automatic check_buttons(input logic exp_user, input logic exp_osd);
	compare_bit("o_btn_user", o_btn_user, exp_user);
	compare_bit("o_btn_osd", o_btn_osd, exp_osd);
endtask

task automatic finish_test(input string name, input int err_base);
	tests_done++;
	$display("Test %s done, %0d errors", name, errors - err_base);
endtask

`endif

// ==== tb/tb_io_hub.sv ====
// Host I/O hub testbench

`timescale 1ns/10ps
`default_nettype none

module tb_io_hub;

	localparam int DEBOUNCE_DIV   = 3;
	localparam int TICK_CYCLES    = DEBOUNCE_DIV + 1;
	// About 1500 cycles of tests, with margin
	localparam int TIMEOUT_CYCLES = 4000;

	logic                             clk;
	logic                             resetd;
	logic                             i_io_sel;
	logic                             i_io_strobe;
	io_hub_pkg::host_word_t           i_io_din;
	logic                             i_btn_user;
	logic                             i_btn_osd;
	io_hub_pkg::status_leds_t         i_status;
	io_hub_pkg::mix_mode_e            i_mix_mode;
	logic                             i_core_signed;
	io_hub_pkg::sample_t              i_core_l;
	io_hub_pkg::sample_t              i_core_r;
	io_hub_pkg::sample_t              i_linux_l;
	io_hub_pkg::sample_t              i_linux_r;
	logic                             o_btn_user;
	logic                             o_btn_osd;
	logic [io_hub_pkg::LED_COUNT-1:0] o_led;
	io_hub_pkg::sample_t              o_audio_l;
	io_hub_pkg::sample_t              o_audio_r;

	int                     errors;
	int                     checks;
	int                     tests_done;
	int                     cycle_count;
	integer                 seed;
	io_hub_pkg::led_cfg_t   exp_led_cfg;
	io_hub_pkg::vol_att_t   exp_att;

	io_hub_top #(
		.DEBOUNCE_DIV(DEBOUNCE_DIV)
	) uut (.*);

	`include "tb_io_hub_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic test_led_reset();
		int err_base;
		err_base = errors;
		for (int k = 0; k < 16; k += 5) begin
			@(negedge clk);
			i_status = io_hub_pkg::status_leds_t'(4'(k));
			@(negedge clk);
			compare_led("o_led", o_led, led_expect(exp_led_cfg, i_status));
		end
		host_write(io_hub_pkg::CMD_LED, 1, 16'hF0A5, 16'h0000);
		exp_led_cfg = io_hub_pkg::led_cfg_t'(16'hF0A5);
		wait_cycles(4);
		compare_led("o_led", o_led, led_expect(exp_led_cfg, i_status));
		@(negedge clk);
		i_status = io_hub_pkg::status_leds_t'(4'b0101);
		@(negedge clk);
		compare_led("o_led", o_led, led_expect(exp_led_cfg, i_status));
		finish_test("led_after_reset", err_base);
	endtask

	task automatic test_cmd_sequence();
		int err_base;
		err_base = errors;
		drive_audio(16'h1234, 16'h0100, 16'hF800, 16'h0040);
		host_write(io_hub_pkg::CMD_VOLUME, 2, 16'h0002, 16'h0001);
		exp_att = io_hub_pkg::vol_att_t'(5'h01);
		wait_cycles(16);
		check_audio();
		// Unknown opcode swallows its data
		host_write(8'h42, 1, 16'h0004, 16'h0000);
		wait_cycles(16);
		check_audio();
		compare_led("o_led", o_led, led_expect(exp_led_cfg, i_status));
		host_select(1'b1);
		send_word({8'h00, io_hub_pkg::CMD_VOLUME});
		send_word(16'h0003);
		host_select(1'b0);
		// Lone word after deselect is a new command
		host_select(1'b1);
		send_word(16'h0005);
		host_select(1'b0);
		exp_att = io_hub_pkg::vol_att_t'(5'h03);
		wait_cycles(16);
		check_audio();
		host_write(io_hub_pkg::CMD_VOLUME, 1, 16'h0000, 16'h0000);
		exp_att = '0;
		wait_cycles(16);
		check_audio();
		finish_test("cmd_sequence", err_base);
	endtask

	task automatic debounce_one(input logic osd);
		set_button(osd, 1'b1);
		wait_cycles(5 * TICK_CYCLES);
		set_button(osd, 1'b0);
		check_buttons(1'b0, 1'b0);
		wait_cycles(12 * TICK_CYCLES);
		check_buttons(1'b0, 1'b0);
		set_button(osd, 1'b1);
		wait_cycles(12 * TICK_CYCLES);
		check_buttons(~osd, osd);
		set_button(osd, 1'b0);
		wait_cycles(12 * TICK_CYCLES);
		check_buttons(1'b0, 1'b0);
	endtask

	task automatic test_debounce();
		int err_base;
		err_base = errors;
		debounce_one(1'b0);
		debounce_one(1'b1);
		finish_test("debounce", err_base);
	endtask

	task automatic test_signed_mix();
		int err_base;
		err_base = errors;
		for (int s = 0; s < 2; s++) begin
			@(negedge clk);
			i_core_signed = s[0];
			for (int n = 0; n < 12; n++) begin
				drive_audio(16'($random(seed)), 16'($random(seed)),
				            16'($random(seed)), 16'($random(seed)));
				check_audio();
			end
			// Saturation at both ends
			drive_audio(16'h7FFF, 16'h7FFF, 16'h8000, 16'h8000);
			check_audio();
			drive_audio(16'hFFFF, 16'h7FFF, 16'h0001, 16'h8000);
			check_audio();
		end
		finish_test("signed_mix", err_base);
	endtask

	task automatic test_cross_mix();
		int err_base;
		err_base = errors;
		for (int m = 1; m < 4; m++) begin
			@(negedge clk);
			i_mix_mode = io_hub_pkg::mix_mode_e'(2'(m));
			for (int n = 0; n < 4; n++) begin
				drive_audio(16'($random(seed)), 16'($random(seed)),
				            16'($random(seed)), 16'($random(seed)));
				check_audio();
			end
			drive_audio(16'h7FFF, 16'h7FFF, 16'h8000, 16'h0400);
			check_audio();
		end
		@(negedge clk);
		i_mix_mode = io_hub_pkg::MIX_NONE;
		finish_test("cross_mix", err_base);
	endtask

	task automatic test_attenuation();
		int err_base;
		int shifts [3];
		err_base = errors;
		shifts = '{0, 3, 15};
		drive_audio(16'h4000, 16'h1234, 16'hD000, 16'hFEDD);
		for (int i = 0; i < 3; i++) begin
			host_write(io_hub_pkg::CMD_VOLUME, 1, 16'(shifts[i]), 16'h0000);
			exp_att = io_hub_pkg::vol_att_t'(5'(shifts[i]));
			wait_cycles(16);
			check_audio();
		end
		host_write(io_hub_pkg::CMD_VOLUME, 1, 16'h0010, 16'h0000);
		exp_att = io_hub_pkg::vol_att_t'(5'h10);
		wait_cycles(16);
		compare_sample("o_audio_l", o_audio_l, 16'sd0);
		compare_sample("o_audio_r", o_audio_r, 16'sd0);
		finish_test("attenuation", err_base);
	endtask

	initial begin
		seed          = 32'h1d16_f064;
		errors        = 0;
		checks        = 0;
		tests_done    = 0;
		exp_led_cfg   = '0;
		exp_att       = '0;
		resetd        = 1'b1;
		i_io_sel      = 1'b0;
		i_io_strobe   = 1'b0;
		i_io_din      = '0;
		i_btn_user    = 1'b0;
		i_btn_osd     = 1'b0;
		i_status      = '0;
		i_mix_mode    = io_hub_pkg::MIX_NONE;
		i_core_signed = 1'b1;
		i_core_l      = '0;
		i_core_r      = '0;
		i_linux_l     = '0;
		i_linux_r     = '0;
		wait_cycles(16);
		resetd = 1'b0;
		wait_cycles(2);

		test_led_reset();
		test_cmd_sequence();
		test_debounce();
		test_signed_mix();
		test_cross_mix();
		test_attenuation();

		$display("Tests: %0d, checks: %0d, errors: %0d", tests_done, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire
